// ==== sources.f ====
+incdir+design
design/cdc_bridge_pkg.sv
design/pointer_synchronizer.sv
design/async_fifo_channel.sv
design/channel_merger.sv
design/dual_cdc_bridge.sv
testbench/dual_cdc_bridge_tb.sv

// ==== Makefile ====
# Verilator build and run of the dual-source CDC bridge testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= dual_cdc_bridge_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/dual_cdc_bridge_tb.sv ====
// Dual-source CDC bridge testbench
// Random traffic on three unrelated clocks, per-channel scoreboards,
// back-pressure fill of channel A and a round-robin check with both full

`timescale 1ns/1ps
`include "cdc_bridge_consts.svh"

module dual_cdc_bridge_tb;

  localparam int TIMEOUT = 1000;
  // Write cycles with ready low before a channel counts as full
  localparam int SETTLE = 16;
  localparam int WAIT_RESET = 0;
  localparam int WAIT_DRAIN = 1;
  localparam int WAIT_A_READY = 2;
  localparam int WAIT_TURNS = 3;

  logic write_a_clock, write_a_resetn, write_a_valid, write_a_ready;
  logic write_b_clock, write_b_resetn, write_b_valid, write_b_ready;
  logic read_clock, read_resetn, out_valid, out_ready;
  cdc_bridge_pkg::data_t    write_a_data, write_b_data, out_data;
  cdc_bridge_pkg::channel_t out_channel;

  // Scoreboards of expected words per channel in write order
  cdc_bridge_pkg::data_t expected_a[$];
  cdc_bridge_pkg::data_t expected_b[$];

  integer seed = 32'h1683549d;
  int     errors = 0;
  int     written = 0;
  int     received = 0;
  int     next_index[2] = '{0, 0};
  // Mode of out_ready is 0 for low, 1 for high and 2 for random
  int     ready_mode = 0;
  bit     check_turns = 0;
  int     turns = 0;
  logic   stalled_q = 1'b0;
  cdc_bridge_pkg::channel_t previous_channel;
  cdc_bridge_pkg::channel_t stalled_channel;
  cdc_bridge_pkg::data_t    stalled_data;

  dual_cdc_bridge dut_i (.*);

  initial begin
    read_clock = 1'b0;
    forever #5 read_clock = ~read_clock;
  end
  initial begin
    write_a_clock = 1'b0;
    forever #3.5 write_a_clock = ~write_a_clock;
  end
  initial begin
    write_b_clock = 1'b0;
    forever #6.5 write_b_clock = ~write_b_clock;
  end

  // Each domain leaves reset after 4 of its own cycles
  initial begin
    {read_resetn, write_a_resetn, write_b_resetn} = 3'b000;
    {write_a_valid, write_b_valid, out_ready} = 3'b000;
    write_a_data = '0;
    write_b_data = '0;
    fork
      begin
        repeat (4) @(posedge read_clock);
        #1 read_resetn = 1'b1;
      end
      begin
        repeat (4) @(posedge write_a_clock);
        #1 write_a_resetn = 1'b1;
      end
      begin
        repeat (4) @(posedge write_b_clock);
        #1 write_b_resetn = 1'b1;
      end
    join_none
  end

  // Sink drives out_ready from the mode 1 ns after each read edge
  initial begin
    logic [31:0] r;
    forever begin
      @(posedge read_clock);
      #1;
      r = $random(seed);
      out_ready = (ready_mode == 1) || ((ready_mode == 2) && r[0]);
    end
  end

  // Stalled output must still be valid one edge later
  hold_valid: assert property (@(posedge read_clock) disable iff (!read_resetn)
      out_valid && !out_ready |=> out_valid)
    else begin
      errors++;
      $display("out_valid dropped while the output was stalled");
    end

  task automatic finish_run();
    $display("Summary: %0d written, %0d received, %0d errors", written, received, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
  endtask

  // Pops the scoreboard of the tagged channel and compares the payload
  task automatic check_word(input cdc_bridge_pkg::channel_t channel,
                            input cdc_bridge_pkg::data_t actual);
    cdc_bridge_pkg::data_t expected;
    bit pending;
    pending = (channel == cdc_bridge_pkg::CHANNEL_A) ? (expected_a.size() > 0)
                                                     : (expected_b.size() > 0);
    assert (pending) else begin
      errors++;
      $display("Word %h came out on %s with no write pending", actual, channel.name());
    end
    if (pending) begin
      expected = (channel == cdc_bridge_pkg::CHANNEL_A) ? expected_a.pop_front()
                                                        : expected_b.pop_front();
      assert (actual == expected) else begin
        errors++;
        $display("ERR out_data on %s expected %h actual %h", channel.name(), expected, actual);
      end
    end
  endtask

  // Output monitor reads the values held before each read edge
  always @(posedge read_clock) begin
    if (stalled_q) begin
      assert (out_channel == stalled_channel) else begin
        errors++;
        $display("ERR out_channel expected %h actual %h", stalled_channel, out_channel);
      end
      assert (out_data == stalled_data) else begin
        errors++;
        $display("ERR out_data expected %h actual %h", stalled_data, out_data);
      end
    end
    stalled_q = read_resetn && out_valid && !out_ready;
    stalled_channel = out_channel;
    stalled_data = out_data;
    if (read_resetn && out_valid && out_ready) begin
      received++;
      check_word(out_channel, out_data);
      // Round robin with both channels loaded
      if (check_turns) begin
        if (turns > 0) begin
          assert (out_channel != previous_channel) else begin
            errors++;
            $display("ERR out_channel expected %h actual %h", !previous_channel, out_channel);
          end
        end
        previous_channel = out_channel;
        turns++;
      end
    end
  end

  task automatic write_edge(input bit channel);
    if (channel) begin
      @(posedge write_b_clock);
    end else begin
      @(posedge write_a_clock);
    end
  endtask

  // Channel A counts up from 10, channel B from 80
  task automatic drive_write(input bit channel, input logic valid);
    if (channel) begin
      write_b_valid = valid;
      write_b_data  = cdc_bridge_pkg::data_t'(8'h80 + next_index[1]);
    end else begin
      write_a_valid = valid;
      write_a_data  = cdc_bridge_pkg::data_t'(8'h10 + next_index[0]);
    end
  endtask

  // Called on a write edge and returns 1 when the driven word was accepted
  function automatic bit take_write(input bit channel);
    if (channel && write_b_valid && write_b_ready) begin
      expected_b.push_back(write_b_data);
    end else if (!channel && write_a_valid && write_a_ready) begin
      expected_a.push_back(write_a_data);
    end else begin
      return 1'b0;
    end
    next_index[channel]++;
    written++;
    return 1'b1;
  endfunction

  // A word offered and not yet taken stays offered
  task automatic send_words(input bit channel, input int count);
    logic [31:0] r;
    int sent;
    int idle;
    bit held;
    sent = 0;
    idle = 0;
    while (sent < count) begin
      write_edge(channel);
      held = 1'b0;
      if (take_write(channel)) begin
        sent++;
        idle = 0;
      end else begin
        held = channel ? write_b_valid : write_a_valid;
        if (++idle > TIMEOUT) begin
          report_timeout("a write to be accepted");
          break;
        end
      end
      #1;
      r = $random(seed);
      drive_write(channel, (r[0] || held) && (sent < count));
    end
  endtask

  // Keeps valid high until ready has stayed low for SETTLE write cycles
  task automatic fill_channel(input bit channel, output int accepted);
    int low_cycles;
    int cycles;
    accepted = 0;
    low_cycles = 0;
    cycles = 0;
    write_edge(channel);
    #1 drive_write(channel, 1'b1);
    while (low_cycles < SETTLE) begin
      write_edge(channel);
      if (take_write(channel)) begin
        accepted++;
        low_cycles = 0;
      end else begin
        low_cycles++;
      end
      if (++cycles > TIMEOUT) begin
        report_timeout("a channel to fill");
        break;
      end
      #1 drive_write(channel, 1'b1);
    end
    drive_write(channel, 1'b0);
  endtask

  task automatic wait_for(input int what);
    int cycles;
    bit done;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge read_clock);
      case (what)
        WAIT_RESET:   done = read_resetn && write_a_resetn && write_b_resetn;
        WAIT_DRAIN:   done = !out_valid && expected_a.size() == 0 && expected_b.size() == 0;
        WAIT_A_READY: done = write_a_ready;
        default:      done = (turns >= 16);
      endcase
      if (!done && ++cycles > TIMEOUT) begin
        report_timeout("the bridge to reach the next phase");
        done = 1'b1;
      end
    end
  endtask

  initial begin : main_sequence
    int accepted_a;
    int accepted_b;
    wait_for(WAIT_RESET);
    assert (!out_valid) else begin
      errors++;
      $display("ERR out_valid expected %h actual %h", 1'b0, out_valid);
    end
    assert (write_a_ready && write_b_ready) else begin
      errors++;
      $display("A write ready was low right after reset");
    end
    // Random valid and out_ready on both channels
    ready_mode = 2;
    fork
      send_words(1'b0, 40);
      send_words(1'b1, 40);
    join
    ready_mode = 1;
    wait_for(WAIT_DRAIN);
    // Channel A under back-pressure where the merger register holds one extra word
    ready_mode = 0;
    repeat (3) @(posedge read_clock);
    fill_channel(1'b0, accepted_a);
    assert (accepted_a == `CDC_FIFO_DEPTH + 1) else begin
      errors++;
      $display("ERR accepted words expected %h actual %h", `CDC_FIFO_DEPTH + 1, accepted_a);
    end
    ready_mode = 1;
    wait_for(WAIT_A_READY);
    wait_for(WAIT_DRAIN);
    // Grants must alternate once both channels are full
    ready_mode = 0;
    repeat (3) @(posedge read_clock);
    fork
      fill_channel(1'b0, accepted_a);
      fill_channel(1'b1, accepted_b);
    join
    turns = 0;
    check_turns = 1'b1;
    ready_mode = 1;
    wait_for(WAIT_TURNS);
    check_turns = 1'b0;
    wait_for(WAIT_DRAIN);
    assert (received == written) else begin
      errors++;
      $display("ERR received expected %h actual %h", written, received);
    end
    finish_run();
  end

endmodule

// ==== design/dual_cdc_bridge.sv ====
// Dual-source CDC bridge top level
// Two asynchronous FIFO channels feed a round-robin merger in the read domain

`timescale 1ns/1ps

module dual_cdc_bridge (
  // Channel A write domain
  input  logic                     write_a_clock,
  input  logic                     write_a_resetn,
  input  logic                     write_a_valid,
  output logic                     write_a_ready,
  input  cdc_bridge_pkg::data_t    write_a_data,
  // Channel B write domain
  input  logic                     write_b_clock,
  input  logic                     write_b_resetn,
  input  logic                     write_b_valid,
  output logic                     write_b_ready,
  input  cdc_bridge_pkg::data_t    write_b_data,
  // Read domain
  input  logic                     read_clock,
  input  logic                     read_resetn,
  output logic                     out_valid,
  input  logic                     out_ready,
  output cdc_bridge_pkg::channel_t out_channel,
  output cdc_bridge_pkg::data_t    out_data
);

  // Read-side links from each channel to the merger
  logic                         a_valid;
  logic                         a_ready;
  cdc_bridge_pkg::data_t        a_data;
  logic                         b_valid;
  logic                         b_ready;
  cdc_bridge_pkg::data_t        b_data;
  cdc_bridge_pkg::tagged_word_t out_word;

  async_fifo_channel channel_a_i (
    .write_clock  (write_a_clock),
    .write_resetn (write_a_resetn),
    .write_valid  (write_a_valid),
    .write_ready  (write_a_ready),
    .write_data   (write_a_data),
    .read_clock   (read_clock),
    .read_resetn  (read_resetn),
    .read_valid   (a_valid),
    .read_ready   (a_ready),
    .read_data    (a_data)
  );

  async_fifo_channel channel_b_i (
    .write_clock  (write_b_clock),
    .write_resetn (write_b_resetn),
    .write_valid  (write_b_valid),
    .write_ready  (write_b_ready),
    .write_data   (write_b_data),
    .read_clock   (read_clock),
    .read_resetn  (read_resetn),
    .read_valid   (b_valid),
    .read_ready   (b_ready),
    .read_data    (b_data)
  );

  channel_merger merger_i (
    .read_clock  (read_clock),
    .read_resetn (read_resetn),
    .a_valid     (a_valid),
    .a_ready     (a_ready),
    .a_data      (a_data),
    .b_valid     (b_valid),
    .b_ready     (b_ready),
    .b_data      (b_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_word    (out_word)
  );

  // Split the tagged word onto the plain output ports
  assign out_channel = out_word.channel;
  assign out_data    = out_word.data;

endmodule

// ==== design/channel_merger.sv ====
// Channel merger
// Round-robin join of two read-domain streams into one registered output,
// each word tagged with the channel it came from

`timescale 1ns/1ps

module channel_merger (
  input  logic                         read_clock,
  input  logic                         read_resetn,
  // Channel A stream
  input  logic                         a_valid,
  output logic                         a_ready,
  input  cdc_bridge_pkg::data_t        a_data,
  // Channel B stream
  input  logic                         b_valid,
  output logic                         b_ready,
  input  cdc_bridge_pkg::data_t        b_data,
  // Merged output stream
  output logic                         out_valid,
  input  logic                         out_ready,
  output cdc_bridge_pkg::tagged_word_t out_word
);

  // Channel that won the most recent grant
  cdc_bridge_pkg::channel_t last_grant_q;

  logic out_valid_q;
  logic can_load;
  logic grant_a;
  logic grant_b;

  // Register free now, or emptied on this same edge
  assign can_load = ~out_valid_q | out_ready;

  // Each channel wins when alone or when the other went last
  assign grant_a = can_load & a_valid &
                   (~b_valid | (last_grant_q == cdc_bridge_pkg::CHANNEL_B));
  assign grant_b = can_load & b_valid &
                   (~a_valid | (last_grant_q == cdc_bridge_pkg::CHANNEL_A));

  // Ready only in the granted cycle, so at most one read per cycle
  assign a_ready = grant_a;
  assign b_ready = grant_b;

  // Control state
  always_ff @(posedge read_clock or negedge read_resetn) begin
    if (!read_resetn) begin
      out_valid_q  <= 1'b0;
      last_grant_q <= cdc_bridge_pkg::CHANNEL_B;
    end else begin
      if (grant_a || grant_b) begin
        out_valid_q <= 1'b1;
      end else if (out_ready) begin
        out_valid_q <= 1'b0;
      end
      if (grant_a) begin
        last_grant_q <= cdc_bridge_pkg::CHANNEL_A;
      end else if (grant_b) begin
        last_grant_q <= cdc_bridge_pkg::CHANNEL_B;
      end
    end
  end

  // Output payload held while stalled
  always_ff @(posedge read_clock) begin
    if (grant_a) begin
      out_word.channel <= cdc_bridge_pkg::CHANNEL_A;
      out_word.data    <= a_data;
    end else if (grant_b) begin
      out_word.channel <= cdc_bridge_pkg::CHANNEL_B;
      out_word.data    <= b_data;
    end
  end

  assign out_valid = out_valid_q;

endmodule

// ==== design/async_fifo_channel.sv ====
// Asynchronous FIFO channel
// Binary and Gray pointers in each domain, synchronized across the boundary
// Full and empty flags from Gray comparisons and a first-word fall-through read

`timescale 1ns/1ps
`include "cdc_bridge_consts.svh"

module async_fifo_channel (
  // Write clock domain
  input  logic                  write_clock,
  input  logic                  write_resetn,
  input  logic                  write_valid,
  output logic                  write_ready,
  input  cdc_bridge_pkg::data_t write_data,
  // Read clock domain
  input  logic                  read_clock,
  input  logic                  read_resetn,
  output logic                  read_valid,
  input  logic                  read_ready,
  output cdc_bridge_pkg::data_t read_data
);

  // Payload storage
  cdc_bridge_pkg::data_t memory [`CDC_FIFO_DEPTH];

  // Write domain pointers
  cdc_bridge_pkg::pointer_t  write_pointer_q;
  cdc_bridge_pkg::pointer_t  write_gray_q;
  cdc_bridge_pkg::pointer_t  write_pointer_next;
  cdc_bridge_pkg::pointer_t  write_gray_next;
  cdc_bridge_pkg::pointer_t  read_gray_in_write;
  logic [`CDC_ADDR_BITS-1:0] write_address;
  logic                      write_full;
  logic                      write_fire;

  // Read domain pointers
  cdc_bridge_pkg::pointer_t  read_pointer_q;
  cdc_bridge_pkg::pointer_t  read_gray_q;
  cdc_bridge_pkg::pointer_t  read_pointer_next;
  cdc_bridge_pkg::pointer_t  read_gray_next;
  cdc_bridge_pkg::pointer_t  write_gray_in_read;
  logic [`CDC_ADDR_BITS-1:0] read_address;
  logic                      read_empty;
  logic                      read_fire;

  // Write side
  // Address drops the wrap bit
  assign write_address      = write_pointer_q[`CDC_ADDR_BITS-1:0];
  assign write_pointer_next = write_pointer_q + 1'b1;
  // Gray code of the next pointer is ready before the edge
  assign write_gray_next    = write_pointer_next ^ (write_pointer_next >> 1);

  // Full when pointers are one lap apart
  // In Gray this means the two top bits inverted and the rest equal
  assign write_full =
      (write_gray_q[`CDC_ADDR_BITS -: 2] == ~read_gray_in_write[`CDC_ADDR_BITS -: 2]) &&
      (write_gray_q[`CDC_ADDR_BITS-2:0] == read_gray_in_write[`CDC_ADDR_BITS-2:0]);

  assign write_ready = ~write_full;
  assign write_fire  = write_valid & write_ready;

  always_ff @(posedge write_clock or negedge write_resetn) begin
    if (!write_resetn) begin
      write_pointer_q <= '0;
      write_gray_q    <= '0;
    end else if (write_fire) begin
      write_pointer_q <= write_pointer_next;
      write_gray_q    <= write_gray_next;
    end
  end

  // Memory write on the same edge as the pointer update
  always_ff @(posedge write_clock) begin
    if (write_fire) begin
      memory[write_address] <= write_data;
    end
  end

  // Read side
  assign read_address      = read_pointer_q[`CDC_ADDR_BITS-1:0];
  assign read_pointer_next = read_pointer_q + 1'b1;
  assign read_gray_next    = read_pointer_next ^ (read_pointer_next >> 1);

  // Empty when the synchronized write pointer has not moved past us
  assign read_empty = (write_gray_in_read == read_gray_q);
  assign read_valid = ~read_empty;
  assign read_fire  = read_valid & read_ready;

  // Head word falls through without a read strobe
  assign read_data = memory[read_address];

  always_ff @(posedge read_clock or negedge read_resetn) begin
    if (!read_resetn) begin
      read_pointer_q <= '0;
      read_gray_q    <= '0;
    end else if (read_fire) begin
      read_pointer_q <= read_pointer_next;
      read_gray_q    <= read_gray_next;
    end
  end

  // Read pointer into the write domain for the full flag
  pointer_synchronizer #(
    .STAGES   (`CDC_SYNC_STAGES)
  ) read_gray_sync_i (
    .clock    (write_clock),
    .resetn   (write_resetn),
    .gray_in  (read_gray_q),
    .gray_out (read_gray_in_write)
  );

  // Write pointer into the read domain for the empty flag
  pointer_synchronizer #(
    .STAGES   (`CDC_SYNC_STAGES)
  ) write_gray_sync_i (
    .clock    (read_clock),
    .resetn   (read_resetn),
    .gray_in  (write_gray_q),
    .gray_out (write_gray_in_read)
  );

endmodule

// ==== design/pointer_synchronizer.sv ====
// Gray pointer synchronizer
// Register chain in the receiving clock domain that carries a Gray-coded
// FIFO pointer across a clock boundary

`timescale 1ns/1ps

module pointer_synchronizer #(
  parameter int STAGES = 2
) (
  input  logic                     clock,
  input  logic                     resetn,
  input  cdc_bridge_pkg::pointer_t gray_in,
  output cdc_bridge_pkg::pointer_t gray_out
);

  // Synchronizer stages where index 0 samples the foreign domain
  cdc_bridge_pkg::pointer_t stage_q [STAGES];

  // Only one bit of gray_in moves per update
  // so a metastable first stage resolves to either the old or new pointer
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < STAGES; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= gray_in;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Last stage is stable in the receiving domain
  assign gray_out = stage_q[STAGES-1];

endmodule

// ==== design/cdc_bridge_pkg.sv ====
// Dual-source CDC bridge types
// Payload word, FIFO pointer and the tagged word leaving the merger

`include "cdc_bridge_consts.svh"

package cdc_bridge_pkg;

  // Payload word pushed by each producer
  typedef logic [`CDC_DATA_WIDTH-1:0] data_t;

  // FIFO pointer with wrap bit in binary or Gray code
  typedef logic [`CDC_ADDR_BITS:0] pointer_t;

  // Source channel tag
  typedef enum logic {
    CHANNEL_A = 1'b0,
    CHANNEL_B = 1'b1
  } channel_t;

  // Output word with the tag in the top bit
  typedef struct packed {
    channel_t channel;
    data_t    data;
  } tagged_word_t;

endpackage

// ==== design/cdc_bridge_consts.svh ====
// Dual-source CDC bridge constants
// Payload width, FIFO geometry and synchronizer depth shared by all blocks

`ifndef CDC_BRIDGE_CONSTS_SVH
`define CDC_BRIDGE_CONSTS_SVH

// Payload word width in bits
`define CDC_DATA_WIDTH 8

// Entries per FIFO channel as a power of two
`define CDC_FIFO_DEPTH 8

// Memory address width as log2 of the depth
// Pointers carry one extra wrap bit on top of this
`define CDC_ADDR_BITS 3

// Flip-flops in each pointer synchronizer chain
`define CDC_SYNC_STAGES 2

`endif
